/* command_sequencer.sv */
module command_sequencer (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  logic                               descriptor_ready_i,
  input  cu_cache_pkg::cache_req_t           req_head_i,
  input  logic                               req_valid_i,
  input  logic                               resp_prog_full_i,
  input  logic                               store_ready_i,
  input  logic                               store_rvalid_i,
  input  logic [cu_cache_pkg::WORD_W-1:0]    store_rdata_i,
  output logic                               req_pop_o,
  output logic                               resp_push_o,
  output cu_cache_pkg::mem_resp_t            resp_o,
  output logic                               store_valid_o,
  output cu_cache_pkg::cache_req_t           store_req_o
);

  // --------------------------------------------------
  // State register
  // --------------------------------------------------
  cu_cache_pkg::seq_state_e state_q;
  cu_cache_pkg::seq_state_e state_d;

  // All issue conditions except the state
  logic head_ok;
  logic head_is_write;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state_q <= cu_cache_pkg::SEQ_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // One cycle in reset, then ready for good
  always_comb begin
    state_d = state_q;
    case (state_q)
      cu_cache_pkg::SEQ_RESET: state_d = cu_cache_pkg::SEQ_READY;
      cu_cache_pkg::SEQ_READY: state_d = cu_cache_pkg::SEQ_READY;
      default:                 state_d = cu_cache_pkg::SEQ_RESET;
    endcase
  end

  // --------------------------------------------------
  // Issue rule
  // --------------------------------------------------
  assign head_ok = req_valid_i & ~resp_prog_full_i & descriptor_ready_i & store_ready_i;
  assign head_is_write = (req_head_i.cmd == cu_cache_pkg::CMD_WRITE);

  always_comb begin
    store_valid_o = 1'b0;
    req_pop_o     = 1'b0;
    resp_push_o   = 1'b0;
    case (state_q)
      cu_cache_pkg::SEQ_READY: begin
        if (store_rvalid_i) begin
          // Read word is back, retire the head
          req_pop_o   = 1'b1;
          resp_push_o = 1'b1;
        end else if (head_ok) begin
          store_valid_o = 1'b1;
          // Writes retire in the issue cycle
          req_pop_o     = head_is_write;
          resp_push_o   = head_is_write;
        end
      end
      default: begin
        store_valid_o = 1'b0;
      end
    endcase
  end

  // --------------------------------------------------
  // Store request and response payload
  // --------------------------------------------------
  always_comb begin
    store_req_o       = req_head_i;
    // Reads never carry strobes
    store_req_o.wstrb = req_head_i.wstrb & {cu_cache_pkg::STRB_W{head_is_write}};
  end

  assign resp_o.cmd  = req_head_i.cmd;
  assign resp_o.id   = req_head_i.id;
  // Read data on rvalid, echoed write data otherwise
  assign resp_o.data = store_rvalid_i ? store_rdata_i : req_head_i.wdata;

endmodule : command_sequencer

/* cu_cache_chk.sv */
module cu_cache_chk (
  input logic                       ap_clk,
  input logic                       areset_control,
  input cu_cache_pkg::seq_state_e   state_i,
  input logic                       resp_push_i,
  input logic                       resp_prog_full_i,
  input logic                       store_valid_i,
  input logic                       store_ready_i,
  input logic                       store_rvalid_i,
  input cu_cache_pkg::cache_req_t   store_req_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // --------------------------------------------------
  // Issue decode
  // --------------------------------------------------
  logic read_issue;

  assign read_issue = store_valid_i & store_ready_i &
                      (store_req_i.cmd == cu_cache_pkg::CMD_READ);

  // Write responses only with FIFO headroom
  a_write_push_room : assert property (@(posedge ap_clk) disable iff (areset_control)
    (resp_push_i && !store_rvalid_i) |-> !resp_prog_full_i)
    else $error("Write response pushed while response FIFO had no headroom");

  // Read responses, headroom checked at issue
  a_read_push_room : assert property (@(posedge ap_clk) disable iff (areset_control)
    (resp_push_i && store_rvalid_i) |-> $past(!resp_prog_full_i))
    else $error("Read response pushed after an issue without FIFO headroom");

  // Word returns one cycle after a read issue
  a_read_return : assert property (@(posedge ap_clk) disable iff (areset_control)
    read_issue |=> store_rvalid_i)
    else $error("Read issue not followed by store read valid");

  a_idle_in_reset : assert property (@(posedge ap_clk) disable iff (areset_control)
    (state_i == cu_cache_pkg::SEQ_RESET) |-> !store_valid_i)
    else $error("Store request issued in sequencer reset state");

  // Reads carry no strobes
  a_read_strobes : assert property (@(posedge ap_clk) disable iff (areset_control)
    (store_valid_i && store_req_i.cmd == cu_cache_pkg::CMD_READ) |-> (store_req_i.wstrb == '0))
    else $error("Read issued with nonzero write strobes");

endmodule : cu_cache_chk

bind command_sequencer cu_cache_chk u_cu_cache_chk (
  .ap_clk           (ap_clk),
  .areset_control   (areset_control),
  .state_i          (state_q),
  .resp_push_i      (resp_push_o),
  .resp_prog_full_i (resp_prog_full_i),
  .store_valid_i    (store_valid_o),
  .store_ready_i    (store_ready_i),
  .store_rvalid_i   (store_rvalid_i),
  .store_req_i      (store_req_o)
);

/* cu_cache_engine.f */
cu_cache_pkg.sv
sync_fifo.sv
request_mapper.sv
command_sequencer.sv
word_store.sv
cu_cache_engine.sv
cu_cache_chk.sv
tb_cu_cache_engine.sv

/* cu_cache_engine.sv */
module cu_cache_engine (
  input  logic                                 ap_clk,
  input  logic                                 areset_control,
  input  logic                                 descriptor_valid_i,
  input  logic [cu_cache_pkg::ADDR_W-1:0]      descriptor_base_i,
  input  logic                                 request_valid_i,
  input  cu_cache_pkg::cmd_e                   request_cmd_i,
  input  logic [cu_cache_pkg::ID_W-1:0]        request_id_i,
  input  logic [cu_cache_pkg::OFFSET_W-1:0]    request_offset_i,
  input  logic [cu_cache_pkg::WORD_W-1:0]      request_wdata_i,
  input  logic [cu_cache_pkg::STRB_W-1:0]      request_wstrb_i,
  input  logic                                 response_pop_i,
  output logic                                 request_prog_full_o,
  output logic                                 response_valid_o,
  output cu_cache_pkg::cmd_e                   response_cmd_o,
  output logic [cu_cache_pkg::ID_W-1:0]        response_id_o,
  output logic [cu_cache_pkg::WORD_W-1:0]      response_data_o,
  output logic                                 done_o
);

  // --------------------------------------------------
  // Internal signals
  // --------------------------------------------------
  // Registered copy of the external reset
  logic areset_int;

  // Descriptor and mapped requests
  logic                     desc_ready;
  logic                     req_push;
  cu_cache_pkg::cache_req_t req_din;

  // Request FIFO
  cu_cache_pkg::cache_req_t req_head;
  logic                     req_pop;
  logic                     req_valid;
  logic                     req_empty;
  logic                     req_prog_full;

  // Response FIFO
  logic                    resp_push;
  cu_cache_pkg::mem_resp_t resp_din;
  cu_cache_pkg::mem_resp_t resp_head;
  logic                    resp_pop;
  logic                    resp_valid;
  logic                    resp_empty;
  logic                    resp_prog_full;

  // Store side
  logic                            store_valid;
  cu_cache_pkg::cache_req_t        store_req;
  logic                            store_ready;
  logic                            store_rvalid;
  logic [cu_cache_pkg::WORD_W-1:0] store_rdata;

  // Done pipeline
  logic idle;
  logic idle_q;

  // --------------------------------------------------
  // Reset register and done
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    areset_int <= areset_control;
  end

  // Nothing queued and no read in flight
  assign idle = req_empty & resp_empty & store_ready;

  always_ff @(posedge ap_clk) begin
    if (areset_int) begin
      idle_q <= 1'b0;
      done_o <= 1'b0;
    end else begin
      idle_q <= idle;
      done_o <= idle_q;
    end
  end

  // Consumer side, pops gated by the head valid
  assign resp_pop            = response_pop_i & ~resp_empty;
  assign response_valid_o    = resp_valid;
  assign response_cmd_o      = resp_head.cmd;
  assign response_id_o       = resp_head.id;
  assign response_data_o     = resp_head.data;
  assign request_prog_full_o = req_prog_full;

  // --------------------------------------------------
  // Instances
  // --------------------------------------------------
  request_mapper u_request_mapper (
    .ap_clk             (ap_clk),
    .areset_control     (areset_int),
    .descriptor_valid_i (descriptor_valid_i),
    .descriptor_base_i  (descriptor_base_i),
    .request_valid_i    (request_valid_i),
    .request_cmd_i      (request_cmd_i),
    .request_id_i       (request_id_i),
    .request_offset_i   (request_offset_i),
    .request_wdata_i    (request_wdata_i),
    .request_wstrb_i    (request_wstrb_i),
    .descriptor_ready_o (desc_ready),
    .push_o             (req_push),
    .push_req_o         (req_din)
  );

  sync_fifo #(
    .payload_t   (cu_cache_pkg::cache_req_t),
    .DEPTH       (cu_cache_pkg::FIFO_DEPTH),
    .PROG_THRESH (cu_cache_pkg::FIFO_PROG_THRESH)
  ) u_req_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_int),
    .wr_en_i        (req_push),
    .din_i          (req_din),
    .rd_en_i        (req_pop),
    .dout_o         (req_head),
    .valid_o        (req_valid),
    .empty_o        (req_empty),
    .full_o         (),
    .prog_full_o    (req_prog_full)
  );

  command_sequencer u_command_sequencer (
    .ap_clk             (ap_clk),
    .areset_control     (areset_int),
    .descriptor_ready_i (desc_ready),
    .req_head_i         (req_head),
    .req_valid_i        (req_valid),
    .resp_prog_full_i   (resp_prog_full),
    .store_ready_i      (store_ready),
    .store_rvalid_i     (store_rvalid),
    .store_rdata_i      (store_rdata),
    .req_pop_o          (req_pop),
    .resp_push_o        (resp_push),
    .resp_o             (resp_din),
    .store_valid_o      (store_valid),
    .store_req_o        (store_req)
  );

  word_store u_word_store (
    .ap_clk         (ap_clk),
    .areset_control (areset_int),
    .valid_i        (store_valid),
    .req_i          (store_req),
    .ready_o        (store_ready),
    .rvalid_o       (store_rvalid),
    .rdata_o        (store_rdata)
  );

  sync_fifo #(
    .payload_t   (cu_cache_pkg::mem_resp_t),
    .DEPTH       (cu_cache_pkg::FIFO_DEPTH),
    .PROG_THRESH (cu_cache_pkg::FIFO_PROG_THRESH)
  ) u_resp_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_int),
    .wr_en_i        (resp_push),
    .din_i          (resp_din),
    .rd_en_i        (resp_pop),
    .dout_o         (resp_head),
    .valid_o        (resp_valid),
    .empty_o        (resp_empty),
    .full_o         (),
    .prog_full_o    (resp_prog_full)
  );

endmodule : cu_cache_engine

/* cu_cache_pkg.sv */
package cu_cache_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  // Data word and its byte strobes
  localparam int WORD_W = 32;
  localparam int STRB_W = WORD_W / 8;

  // Byte address formed from base plus offset
  localparam int ADDR_W   = 32;
  localparam int OFFSET_W = 16;
  localparam int ID_W     = 8;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  // On-chip word store
  localparam int STORE_INDEX_W = 8;
  localparam int STORE_WORDS   = 256;

  // Request and response queues
  localparam int FIFO_DEPTH       = 16;
  localparam int FIFO_PROG_THRESH = 12;

  // --------------------------------------------------
  // Types
  // --------------------------------------------------
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_e;

  // Request as seen by the word store
  typedef struct packed {
    cmd_e                     cmd;
    logic [ID_W-1:0]          id;
    logic [STORE_INDEX_W-1:0] index;
    logic [WORD_W-1:0]        wdata;
    logic [STRB_W-1:0]        wstrb;
  } cache_req_t;

  // Response handed back to the consumer
  typedef struct packed {
    cmd_e            cmd;
    logic [ID_W-1:0] id;
    logic [WORD_W-1:0] data;
  } mem_resp_t;

  // Command sequencer states
  typedef enum logic {
    SEQ_RESET = 1'b0,
    SEQ_READY = 1'b1
  } seq_state_e;

endpackage : cu_cache_pkg

/* request_mapper.sv */
module request_mapper (
  input  logic                                 ap_clk,
  input  logic                                 areset_control,
  input  logic                                 descriptor_valid_i,
  input  logic [cu_cache_pkg::ADDR_W-1:0]      descriptor_base_i,
  input  logic                                 request_valid_i,
  input  cu_cache_pkg::cmd_e                   request_cmd_i,
  input  logic [cu_cache_pkg::ID_W-1:0]        request_id_i,
  input  logic [cu_cache_pkg::OFFSET_W-1:0]    request_offset_i,
  input  logic [cu_cache_pkg::WORD_W-1:0]      request_wdata_i,
  input  logic [cu_cache_pkg::STRB_W-1:0]      request_wstrb_i,
  output logic                                 descriptor_ready_o,
  output logic                                 push_o,
  output cu_cache_pkg::cache_req_t             push_req_o
);

  // --------------------------------------------------
  // Descriptor
  // --------------------------------------------------
  logic [cu_cache_pkg::ADDR_W-1:0] base_q;
  logic                            desc_valid_q;

  // Stage one holds the raw request
  logic                              s1_valid_q;
  cu_cache_pkg::cmd_e                s1_cmd_q;
  logic [cu_cache_pkg::ID_W-1:0]     s1_id_q;
  logic [cu_cache_pkg::OFFSET_W-1:0] s1_offset_q;
  logic [cu_cache_pkg::WORD_W-1:0]   s1_wdata_q;
  logic [cu_cache_pkg::STRB_W-1:0]   s1_wstrb_q;

  // Byte address of the stage one request
  logic [cu_cache_pkg::ADDR_W-1:0] byte_addr;

  assign descriptor_ready_o = desc_valid_q;
  assign byte_addr = base_q + {{(cu_cache_pkg::ADDR_W - cu_cache_pkg::OFFSET_W){1'b0}},
                               s1_offset_q};

  // Valid flag sticks until reset
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      desc_valid_q <= 1'b0;
    end else if (descriptor_valid_i) begin
      desc_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (descriptor_valid_i) begin
      base_q <= descriptor_base_i;
    end
  end

  // --------------------------------------------------
  // Two-stage pipeline
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      s1_valid_q <= 1'b0;
      push_o     <= 1'b0;
    end else begin
      s1_valid_q <= request_valid_i;
      push_o     <= s1_valid_q;
    end
  end

  // Payload stages
  always_ff @(posedge ap_clk) begin
    s1_cmd_q    <= request_cmd_i;
    s1_id_q     <= request_id_i;
    s1_offset_q <= request_offset_i;
    s1_wdata_q  <= request_wdata_i;
    s1_wstrb_q  <= request_wstrb_i;
    push_req_o.cmd   <= s1_cmd_q;
    push_req_o.id    <= s1_id_q;
    // Drop the byte bits, keep the store index
    push_req_o.index <= byte_addr[$clog2(cu_cache_pkg::STRB_W) +: cu_cache_pkg::STORE_INDEX_W];
    push_req_o.wdata <= s1_wdata_q;
    push_req_o.wstrb <= s1_wstrb_q;
  end

endmodule : request_mapper

/* sync_fifo.sv */
module sync_fifo #(
  parameter type payload_t   = logic,
  parameter int  DEPTH       = 16,
  parameter int  PROG_THRESH = 12
) (
  input  logic     ap_clk,
  input  logic     areset_control,
  input  logic     wr_en_i,
  input  payload_t din_i,
  input  logic     rd_en_i,
  output payload_t dout_o,
  output logic     valid_o,
  output logic     empty_o,
  output logic     full_o,
  output logic     prog_full_o
);

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------
  payload_t                 mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(DEPTH):0]   count_q;

  logic do_write;
  logic do_read;

  // Push into a full FIFO is dropped
  assign do_write = wr_en_i & ~full_o;
  // Pop of an empty FIFO is ignored
  assign do_read  = rd_en_i & ~empty_o;

  // --------------------------------------------------
  // Status flags
  // --------------------------------------------------
  assign empty_o     = (count_q == '0);
  assign full_o      = (count_q == DEPTH);
  assign prog_full_o = (count_q >= PROG_THRESH);
  assign valid_o     = ~empty_o;

  // First word falls through
  assign dout_o = mem_q[rd_ptr_q];

  // Pointer and fill count
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_write) begin
        // Wrap at the last entry
        if (wr_ptr_q == DEPTH - 1) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (do_read) begin
        if (rd_ptr_q == DEPTH - 1) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Simultaneous push and pop keeps the level
      case ({do_write, do_read})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload array
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem_q[wr_ptr_q] <= din_i;
    end
  end

endmodule : sync_fifo

/* tb_cu_cache_engine.sv */
module tb_cu_cache_engine;

  timeunit 1ns;
  timeprecision 100ps;

  // --------------------------------------------------
  // Test entry and table
  // --------------------------------------------------
  typedef struct {
    string                             name;
    logic [cu_cache_pkg::ADDR_W-1:0]   base;
    cu_cache_pkg::cmd_e                cmd;
    logic [cu_cache_pkg::ID_W-1:0]     id;
    logic [cu_cache_pkg::OFFSET_W-1:0] offset;
    logic [cu_cache_pkg::WORD_W-1:0]   wdata;
    logic [cu_cache_pkg::STRB_W-1:0]   wstrb;
    logic [cu_cache_pkg::WORD_W-1:0]   exp_data;
  } test_entry_t;

  test_entry_t tests[$];
  // Table indices of responses still owed, in request order
  int          sb_q[$];
  // Model of the word store contents
  logic [cu_cache_pkg::WORD_W-1:0] shadow [cu_cache_pkg::STORE_WORDS];

  // DUT signals
  logic                              ap_clk = 1'b0;
  logic                              areset_control;
  logic                              descriptor_valid_i;
  logic [cu_cache_pkg::ADDR_W-1:0]   descriptor_base_i;
  logic                              request_valid_i;
  cu_cache_pkg::cmd_e                request_cmd_i;
  logic [cu_cache_pkg::ID_W-1:0]     request_id_i;
  logic [cu_cache_pkg::OFFSET_W-1:0] request_offset_i;
  logic [cu_cache_pkg::WORD_W-1:0]   request_wdata_i;
  logic [cu_cache_pkg::STRB_W-1:0]   request_wstrb_i;
  logic                              response_pop_i;
  logic                              request_prog_full_o;
  logic                              response_valid_o;
  cu_cache_pkg::cmd_e                response_cmd_o;
  logic [cu_cache_pkg::ID_W-1:0]     response_id_o;
  logic [cu_cache_pkg::WORD_W-1:0]   response_data_o;
  logic                              done_o;

  int errors = 0;
  int checks = 0;
  int cycle_count = 0;
  int timeout_limit = 0;
  // Cycles left during which the consumer pops nothing
  int hold_cycles = 0;
  int bp_first;
  int bp_last;
  // Request FIFO reached its threshold at least once
  bit prog_full_seen = 1'b0;

  cu_cache_engine dut_i (.*);

  always #5 ap_clk = ~ap_clk;

  // Run limit scales with the table length
  always @(posedge ap_clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles with %0d responses outstanding",
               cycle_count, sb_q.size());
      $display("Test failed");
      $finish;
    end
  end

  always @(posedge ap_clk) begin
    if (request_prog_full_o === 1'b1) begin
      prog_full_seen = 1'b1;
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  // Inputs move 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge ap_clk);
    #1;
  endtask

  function automatic int word_index(logic [31:0] base, logic [15:0] offset);
    logic [31:0] byte_addr;
    byte_addr = base + {16'h0, offset};
    return int'(byte_addr[9:2]);
  endfunction

  task automatic add_test(string name, logic [31:0] base, cu_cache_pkg::cmd_e cmd,
                          logic [7:0] id, logic [15:0] offset, logic [31:0] wdata,
                          logic [3:0] wstrb);
    test_entry_t e;
    e.name     = name;
    e.base     = base;
    e.cmd      = cmd;
    e.id       = id;
    e.offset   = offset;
    e.wdata    = wdata;
    e.wstrb    = wstrb;
    e.exp_data = '0;
    tests.push_back(e);
  endtask

  // Walk the table in order against the shadow store
  task automatic predict_expected();
    int idx;
    for (int i = 0; i < tests.size(); i++) begin
      idx = word_index(tests[i].base, tests[i].offset);
      if (tests[i].cmd == cu_cache_pkg::CMD_WRITE) begin
        for (int b = 0; b < cu_cache_pkg::STRB_W; b++) begin
          if (tests[i].wstrb[b]) begin
            shadow[idx][b*8 +: 8] = tests[i].wdata[b*8 +: 8];
          end
        end
        // Write response echoes the data as sent
        tests[i].exp_data = tests[i].wdata;
      end else begin
        tests[i].exp_data = shadow[idx];
      end
    end
  endtask

  task automatic send_descriptor(logic [31:0] base);
    descriptor_valid_i = 1'b1;
    descriptor_base_i  = base;
    next_cycle();
    descriptor_valid_i = 1'b0;
  endtask

  task automatic send_request(int i);
    request_valid_i  = 1'b1;
    request_cmd_i    = tests[i].cmd;
    request_id_i     = tests[i].id;
    request_offset_i = tests[i].offset;
    request_wdata_i  = tests[i].wdata;
    request_wstrb_i  = tests[i].wstrb;
    sb_q.push_back(i);
    next_cycle();
    request_valid_i = 1'b0;
  endtask

  // --------------------------------------------------
  // Consumer and scoreboard
  // --------------------------------------------------
  initial begin
    int  idx;
    bit  holding;
    void'($urandom(95));
    forever begin
      @(posedge ap_clk);
      holding = (hold_cycles > 0);
      if (holding) begin
        hold_cycles = hold_cycles - 1;
      end
      #1;
      response_pop_i = 1'b0;
      if (response_valid_o === 1'b1) begin
        if (sb_q.size() == 0) begin
          errors++;
          $display("Unexpected response with id %h and no request outstanding", response_id_o);
          response_pop_i = 1'b1;
        end else if (!holding && ($urandom % 4) != 0) begin
          idx = sb_q.pop_front();
          checks++;
          if (response_cmd_o != tests[idx].cmd) begin
            errors++;
            $display("ERROR %s cmd: expected %0d actual %0d", tests[idx].name,
                     tests[idx].cmd, response_cmd_o);
          end
          if (response_id_o != tests[idx].id) begin
            errors++;
            $display("ERROR %s id: expected %h actual %h", tests[idx].name,
                     tests[idx].id, response_id_o);
          end
          if (response_data_o != tests[idx].exp_data) begin
            errors++;
            $display("ERROR %s data: expected %h actual %h", tests[idx].name,
                     tests[idx].exp_data, response_data_o);
          end
          response_pop_i = 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // Producer and main sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] cur_base;
    bit          base_loaded;
    areset_control     = 1'b1;
    descriptor_valid_i = 1'b0;
    descriptor_base_i  = '0;
    request_valid_i    = 1'b0;
    request_cmd_i      = cu_cache_pkg::CMD_READ;
    request_id_i       = '0;
    request_offset_i   = '0;
    request_wdata_i    = '0;
    request_wstrb_i    = '0;
    response_pop_i     = 1'b0;
    base_loaded        = 1'b0;
    cur_base           = '0;

    // Write then read back
    add_test("wr_rd_write", 32'h0000_1000, cu_cache_pkg::CMD_WRITE, 8'h01, 16'h0010,
             32'hCAFE_F00D, 4'hF);
    add_test("wr_rd_read", 32'h0000_1000, cu_cache_pkg::CMD_READ, 8'h02, 16'h0010, '0, 4'hF);
    // Byte merge under partial strobes
    add_test("strb_full", 32'h0000_1000, cu_cache_pkg::CMD_WRITE, 8'h03, 16'h0020,
             32'h1122_3344, 4'hF);
    add_test("strb_part", 32'h0000_1000, cu_cache_pkg::CMD_WRITE, 8'h04, 16'h0020,
             32'hAABB_CCDD, 4'b0101);
    add_test("strb_read", 32'h0000_1000, cu_cache_pkg::CMD_READ, 8'h05, 16'h0020, '0, 4'h0);
    // Same offset under two bases
    add_test("base_a_wr", 32'h0000_1000, cu_cache_pkg::CMD_WRITE, 8'h06, 16'h0040,
             32'h0A0A_0A0A, 4'hF);
    add_test("base_b_wr", 32'h0000_2040, cu_cache_pkg::CMD_WRITE, 8'h07, 16'h0040,
             32'h0B0B_0B0B, 4'hF);
    add_test("base_b_rd", 32'h0000_2040, cu_cache_pkg::CMD_READ, 8'h08, 16'h0040, '0, 4'h0);
    add_test("base_a_rd", 32'h0000_1000, cu_cache_pkg::CMD_READ, 8'h09, 16'h0040, '0, 4'h0);
    // Burst for back-pressure, distinct data per word
    bp_first = tests.size();
    for (int k = 0; k < 16; k++) begin
      add_test($sformatf("bp_wr_%0d", k), 32'h0000_1000, cu_cache_pkg::CMD_WRITE,
               8'(16 + k), 16'(16'h0100 + 4 * k), {8'(k), 8'h5A, 8'(255 - k), 8'hC3}, 4'hF);
    end
    for (int k = 0; k < 8; k++) begin
      add_test($sformatf("bp_rd_%0d", k), 32'h0000_1000, cu_cache_pkg::CMD_READ,
               8'(40 + k), 16'(16'h0100 + 4 * k), '0, 4'h0);
    end
    bp_last = tests.size() - 1;
    predict_expected();
    timeout_limit = tests.size() * 20 + 200;

    repeat (3) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;

    // Idle after reset until done rises
    while (done_o !== 1'b1) begin
      checks++;
      if (response_valid_o !== 1'b0) begin
        errors++;
        $display("ERROR after_reset valid: expected 0 actual %b", response_valid_o);
      end
      next_cycle();
    end

    for (int i = 0; i < tests.size(); i++) begin
      if (!base_loaded || tests[i].base != cur_base) begin
        // Earlier requests must clear the mapper first
        repeat (3) next_cycle();
        send_descriptor(tests[i].base);
        cur_base    = tests[i].base;
        base_loaded = 1'b1;
      end
      if (i == bp_first) begin
        hold_cycles = 40;
      end
      while (request_prog_full_o) begin
        next_cycle();
      end
      send_request(i);
      if (i == bp_last) begin
        checks++;
        if (done_o !== 1'b0) begin
          errors++;
          $display("ERROR bp_done: expected 0 actual %b", done_o);
        end
      end
    end

    // Drain, then done after two more registers
    while (sb_q.size() != 0) begin
      next_cycle();
    end
    while (response_valid_o) begin
      next_cycle();
    end
    repeat (2) next_cycle();
    checks++;
    if (done_o !== 1'b1) begin
      errors++;
      $display("ERROR final_done: expected 1 actual %b", done_o);
    end

    // Held responses backed up into the request FIFO
    checks++;
    if (!prog_full_seen) begin
      errors++;
      $display("ERROR bp_prog_full: expected 1 actual 0");
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_cu_cache_engine

/* word_store.sv */
module word_store (
  input  logic                             ap_clk,
  input  logic                             areset_control,
  input  logic                             valid_i,
  input  cu_cache_pkg::cache_req_t         req_i,
  output logic                             ready_o,
  output logic                             rvalid_o,
  output logic [cu_cache_pkg::WORD_W-1:0]  rdata_o
);

  // --------------------------------------------------
  // Word array and read index
  // --------------------------------------------------
  logic [cu_cache_pkg::WORD_W-1:0]        mem_q [cu_cache_pkg::STORE_WORDS];
  logic [cu_cache_pkg::STORE_INDEX_W-1:0] rd_index_q;

  logic accept;
  logic is_read;

  assign accept  = valid_i & ready_o;
  assign is_read = (req_i.cmd == cu_cache_pkg::CMD_READ);

  // Ready drops for one cycle after a read
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready_o  <= 1'b1;
      rvalid_o <= 1'b0;
    end else begin
      ready_o  <= ~(accept & is_read);
      rvalid_o <= accept & is_read;
    end
  end

  // Index latched in the issue cycle
  always_ff @(posedge ap_clk) begin
    if (accept & is_read) begin
      rd_index_q <= req_i.index;
    end
  end

  // Byte lanes under the strobes
  always_ff @(posedge ap_clk) begin
    if (accept & ~is_read) begin
      for (int b = 0; b < cu_cache_pkg::STRB_W; b++) begin
        if (req_i.wstrb[b]) begin
          mem_q[req_i.index][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Word shown with rvalid
  assign rdata_o = mem_q[rd_index_q];

endmodule : word_store
